//--- list.f
+incdir+src
src/booth_pkg.sv
src/booth_ctrl_if.sv
src/booth_fsm.sv
src/booth_datapath.sv
src/booth_mult_top.sv
sim/booth_clock_gen.sv
sim/booth_mult_sva.sv
sim/booth_mult_tb.sv

//--- Makefile
# Verilator build and run for the radix-4 Booth multiplier.

VERILATOR ?= verilator
TOP       ?= booth_mult_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= sim passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard src/*.sv src/*.svh sim/*.sv)
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BINARY) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "result: PASS"; \
	else \
		echo "result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/booth_testdata.txt
# columns: operand a, operand b, expected signed product (hex, 8-bit operands)
# products are two's complement, 16 bits
80 80 4000
80 7f c080
7f 7f 3f01
7f 80 c080
00 5a 0000
5a 00 0000
ff ff 0001
ff 01 ffff
01 ff ffff
13 0f 011d
13 33 03c9
25 cc f87c
e7 06 ff6a
3a 69 17ca
c5 96 186e
4d aa e622
9c 55 decc
80 01 ff80
7f ff ff81
80 ff 0080
b3 3c edf4
02 fe fffc
ff 80 0080
06 fb ffe2
fa fa 0024
40 40 1000
c0 40 f000
81 81 3f01

//--- sim/booth_mult_tb.sv
`timescale 1ns/1ps

`include "booth_defines.svh"

module booth_mult_tb
	import booth_pkg::*;
();

	localparam int				DRIVE_DLY	= 1;
	localparam int				N_RANDOM	= 64;
	localparam int				LAT			= `BOOTH_LATENCY;
	localparam int unsigned		SEED		= 32'h50e5_b43f;

	logic		CLOCK;
	logic		RESET;
	logic		reset_req;
	logic		start;
	logic		done;
	operand_t	a;
	operand_t	b;
	product_t	product;

	operand_t	vec_a[$];
	operand_t	vec_b[$];
	product_t	vec_p[$];

	int			err_count;
	int			test_count;
	int			test_fail;
	int			timeout_limit;
	int			cycle_count;

	booth_clock_gen clk0 (
		.CLOCK		(CLOCK),
		.RESET		(RESET),
		.reset_req	(reset_req)
	);

	booth_mult_top dut0 (
		.CLOCK		(CLOCK),
		.RESET		(RESET),
		.start		(start),
		.a			(a),
		.b			(b),
		.product	(product),
		.done		(done)
	);

	// ==============================
	// reference and checks
	// ==============================

	function automatic product_t signed_product(input operand_t x, input operand_t y);
		product_t px;
		product_t py;
		px = product_t'(x);		// sign extended.
		py = product_t'(y);
		return px * py;
	endfunction

	task automatic check_product(input string name, input product_t actual,
			input product_t expected);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
			err_count++;
		end
	endtask

	task automatic check_done(input int cycles);
		if (cycles != LAT) begin
			$display("done came %0d cycles after start instead of %0d", cycles, LAT);
			err_count++;
		end
	endtask

	task automatic check_quiet(input int n);
		int i;
		for (i = 0; i < n; i++) begin
			@(negedge CLOCK);
			if (done !== 1'b0) begin
				$display("done went high with no product in progress");
				err_count++;
			end
		end
	endtask

	task automatic report_test(input string label, input int errs_before);
		test_count++;
		if (err_count == errs_before) begin
			$display("test %0d %s: ok", test_count, label);
		end else begin
			test_fail++;
			$display("test %0d %s: FAILED", test_count, label);
		end
	endtask

	// ==============================
	// stimulus
	// ==============================

	task automatic start_product(input operand_t op_a, input operand_t op_b);
		@(posedge CLOCK);
		#DRIVE_DLY;
		start	= 1'b1;
		a		= op_a;
		b		= op_b;
		@(posedge CLOCK);
		#DRIVE_DLY;
		start	= 1'b0;
	endtask

	// counts cycles after the accepting edge.
	task automatic wait_done(output int cycles);
		cycles = 0;
		do begin
			@(negedge CLOCK);
			cycles++;
		end while (done !== 1'b1);
	endtask

	task automatic run_vector(input string label, input operand_t op_a,
			input operand_t op_b, input product_t expected);
		int cycles;
		int errs_before;
		errs_before = err_count;
		start_product(op_a, op_b);
		wait_done(cycles);
		check_done(cycles);
		check_product("product", product, expected);
		report_test(label, errs_before);
	endtask

	task automatic load_vectors();
		int			fd;
		int			n;
		string		line;
		operand_t	fa;
		operand_t	fb;
		product_t	fp;
		fd = $fopen("sim/booth_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open sim/booth_testdata.txt");
			err_count++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#") begin
				continue;
			end
			n = $sscanf(line, "%h %h %h", fa, fb, fp);
			if (n == 3) begin
				vec_a.push_back(fa);
				vec_b.push_back(fb);
				vec_p.push_back(fp);
			end else begin
				$display("unreadable line in test data: %s", line);
				err_count++;
			end
		end
		$fclose(fd);
		if (vec_a.size() == 0) begin
			$display("no test vectors found in sim/booth_testdata.txt");
			err_count++;
		end
	endtask

	// ==============================
	// run limit
	// ==============================

	initial begin
		cycle_count = 0;
		while (timeout_limit == 0 || cycle_count < timeout_limit) begin
			@(posedge CLOCK);
			cycle_count++;
		end
		$display("timeout: run did not finish within %0d cycles", timeout_limit);
		$display("sim failed");
		$finish;
	end

	// ==============================
	// test sequence
	// ==============================

	initial begin
		int			i;
		int			cycles;
		int			errs_before;
		int			n_file;
		operand_t	ra;
		operand_t	rb;
		start			= 1'b0;
		a				= '0;
		b				= '0;
		reset_req		= 1'b0;
		err_count		= 0;
		test_count		= 0;
		test_fail		= 0;
		timeout_limit	= 0;
		void'($urandom(SEED));
		load_vectors();
		n_file = vec_a.size();
		for (i = 0; i < N_RANDOM; i++) begin
			ra = operand_t'($urandom());
			rb = operand_t'($urandom());
			vec_a.push_back(ra);
			vec_b.push_back(rb);
			vec_p.push_back(signed_product(ra, rb));
		end
		timeout_limit = (vec_a.size() + 4) * (LAT + 3);
		wait (RESET === 1'b1);

		for (i = 0; i < vec_a.size(); i++) begin
			run_vector($sformatf("%s %h * %h", (i < n_file) ? "file" : "random",
				vec_a[i], vec_b[i]), vec_a[i], vec_b[i], vec_p[i]);
		end

		// second start while busy must be dropped.
		errs_before = err_count;
		start_product(operand_t'(93), operand_t'(-58));
		fork
			wait_done(cycles);
			begin
				repeat (3) @(posedge CLOCK);
				#DRIVE_DLY;
				start	= 1'b1;
				a		= operand_t'(-11);
				b		= operand_t'(77);
				@(posedge CLOCK);
				#DRIVE_DLY;
				start	= 1'b0;
			end
		join
		check_done(cycles);
		check_product("product", product, signed_product(operand_t'(93), operand_t'(-58)));
		check_quiet(LAT + 2);
		report_test("start while busy", errs_before);

		// new start in the cycle after done.
		errs_before = err_count;
		start_product(operand_t'(-101), operand_t'(37));
		wait_done(cycles);
		check_done(cycles);
		check_product("product", product, signed_product(operand_t'(-101), operand_t'(37)));
		start_product(operand_t'(64), operand_t'(-3));
		wait_done(cycles);
		check_done(cycles);
		check_product("product", product, signed_product(operand_t'(64), operand_t'(-3)));
		report_test("back-to-back", errs_before);

		// reset in the middle of a product.
		errs_before = err_count;
		start_product(operand_t'(-77), operand_t'(105));
		repeat (4) @(posedge CLOCK);
		#DRIVE_DLY;
		reset_req = 1'b1;
		for (i = 0; i < 3; i++) begin
			@(negedge CLOCK);
			if (done !== 1'b0) begin
				$display("done went high while reset was asserted");
				err_count++;
			end
			check_product("product", product, '0);
		end
		@(posedge CLOCK);
		#DRIVE_DLY;
		reset_req = 1'b0;
		check_quiet(LAT);		// past where the aborted done would be.
		start_product(operand_t'(-128), operand_t'(-128));
		wait_done(cycles);
		check_done(cycles);
		check_product("product", product, signed_product(operand_t'(-128), operand_t'(-128)));
		report_test("reset mid-product", errs_before);

		$display("tests run: %0d, tests failed: %0d, check errors: %0d",
			test_count, test_fail, err_count);
		if (err_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- sim/booth_mult_sva.sv
`timescale 1ns/1ps

`include "booth_defines.svh"

module booth_mult_sva (
	input logic	CLOCK,
	input logic	RESET,
	input logic	start,
	input logic	load,		// high only when start is taken in IDLE.
	input logic	done
);

	localparam int	LAT	= `BOOTH_LATENCY;

	// ==============================
	// strobe timing
	// ==============================

	done_single: assert property (@(posedge CLOCK) disable iff (!RESET)
		done |=> !done)
		else $error("done was high in two consecutive cycles");

	done_latency: assert property (@(posedge CLOCK) disable iff (!RESET)
		(start && load) |-> ##LAT done)
		else $error("done missing at the expected latency after an accepted start");

	done_has_start: assert property (@(posedge CLOCK) disable iff (!RESET)
		done |-> $past(start && load, LAT))
		else $error("done raised without an accepted start before it");

endmodule

bind booth_mult_top booth_mult_sva sva0 (
	.CLOCK	(CLOCK),
	.RESET	(RESET),
	.start	(start),
	.load	(ctl_if.load),
	.done	(done)
);

//--- sim/booth_clock_gen.sv
`timescale 1ns/1ps

module booth_clock_gen (
	output logic	CLOCK,
	output logic	RESET,
	input logic		reset_req		// extra reset from the testbench.
);

	logic	por_n;

	initial begin
		CLOCK = 1'b0;
		forever #4 CLOCK = ~CLOCK;		// 8 ns period.
	end

	initial begin
		por_n = 1'b0;
		repeat (3) @(posedge CLOCK);
		#1;
		por_n = 1'b1;
	end

	assign RESET = por_n & ~reset_req;

endmodule

//--- src/booth_mult_top.sv
`timescale 1ns/1ps

module booth_mult_top
	import booth_pkg::*;
(
	input logic			CLOCK,
	input logic			RESET,
	input logic			start,		// one-cycle strobe.
	input operand_t		a,
	input operand_t		b,
	output product_t	product,
	output logic		done		// one-cycle strobe.
);

	// ==============================
	// control bundle
	// ==============================

	booth_ctrl_if ctl_if ();

	// ==============================
	// sequencer
	// ==============================

	booth_fsm fsm0 (
		.CLOCK	(CLOCK),
		.RESET	(RESET),
		.start	(start),
		.done	(done),
		.ctl	(ctl_if.ctrl)
	);

	// ==============================
	// datapath
	// ==============================

	booth_datapath dp0 (
		.CLOCK		(CLOCK),
		.RESET		(RESET),
		.a			(a),
		.b			(b),
		.product	(product),
		.dp			(ctl_if.dp)
	);

endmodule

//--- src/booth_datapath.sv
`timescale 1ns/1ps

`include "booth_defines.svh"

module booth_datapath
	import booth_pkg::*;
(
	input logic			CLOCK,
	input logic			RESET,
	input operand_t		a,
	input operand_t		b,
	output product_t	product,
	booth_ctrl_if.dp	dp
);

	localparam int	W	= `BOOTH_WIDTH;
	localparam int	AW	= `BOOTH_WIDTH + 2;		// room for +-2M.

	operand_t				m_reg;			// multiplicand.
	logic signed [AW-1:0]	acc;
	logic [W-1:0]			mplr;			// multiplier, shifted out low.
	logic					app_bit;		// bit appended below the multiplier.

	logic signed [AW-1:0]	m_ext;
	logic signed [AW-1:0]	m_dbl;
	logic signed [AW-1:0]	sum;
	logic signed [AW+W:0]	pair_sh;

	// ==============================
	// add/subtract unit
	// ==============================

	assign m_ext = {{2{m_reg[W-1]}}, m_reg};
	assign m_dbl = m_ext <<< 1;

	always_comb begin
		case (dp.op)
			OP_ADD_M: begin
				sum = acc + m_ext;
			end
			OP_ADD_2M: begin
				sum = acc + m_dbl;
			end
			OP_SUB_M: begin
				sum = acc - m_ext;
			end
			OP_SUB_2M: begin
				sum = acc - m_dbl;
			end
			default: begin
				sum = acc;
			end
		endcase
	end

	// whole pair moves right, sign taken from acc.
	assign pair_sh = $signed({acc, mplr, app_bit}) >>> 2;

	// ==============================
	// multiplicand register
	// ==============================

	always_ff @(posedge CLOCK) begin
		if (dp.load) begin
			m_reg <= a;
		end
	end

	// ==============================
	// accumulator
	// ==============================

	always_ff @(posedge CLOCK or negedge RESET) begin
		if (!RESET) begin
			acc <= '0;
		end else if (dp.load) begin
			acc <= '0;
		end else if (dp.op_en) begin
			acc <= sum;
		end else if (dp.shift) begin
			acc <= pair_sh[AW+W:W+1];
		end
	end

	// ==============================
	// multiplier and appended bit
	// ==============================

	always_ff @(posedge CLOCK or negedge RESET) begin
		if (!RESET) begin
			mplr	<= '0;
			app_bit	<= 1'b0;
		end else if (dp.load) begin
			mplr	<= b;
			app_bit	<= 1'b0;
		end else if (dp.shift) begin
			mplr	<= pair_sh[W:1];
			app_bit	<= pair_sh[0];
		end
	end

	// ==============================
	// outputs
	// ==============================

	assign dp.recode	= {mplr[1:0], app_bit};
	assign product		= {acc[W-1:0], mplr};		// appended bit dropped.

endmodule

//--- src/booth_fsm.sv
`timescale 1ns/1ps

`include "booth_defines.svh"

module booth_fsm
	import booth_pkg::*;
(
	input logic			CLOCK,
	input logic			RESET,
	input logic			start,
	output logic		done,
	booth_ctrl_if.ctrl	ctl
);

	localparam int				CNT_W		= $clog2(`BOOTH_ITER + 1);
	localparam logic [CNT_W-1:0]	LAST_ITER	= CNT_W'(`BOOTH_ITER - 1);

	booth_state_e		state;
	booth_state_e		state_nxt;
	logic [CNT_W-1:0]	iter_cnt;
	booth_op_e			win_op;

	// standard radix-4 table over {q1, q0, q-1}.
	function automatic booth_op_e recode_op(input logic [2:0] win);
		booth_op_e res;
		case (win)
			3'b001, 3'b010:	res = OP_ADD_M;
			3'b011:			res = OP_ADD_2M;
			3'b100:			res = OP_SUB_2M;
			3'b101, 3'b110:	res = OP_SUB_M;
			default:		res = OP_NONE;		// 000 and 111.
		endcase
		return res;
	endfunction

	assign win_op = recode_op(ctl.recode);

	// ==============================
	// state register
	// ==============================

	always_ff @(posedge CLOCK or negedge RESET) begin
		if (!RESET) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (start) begin
					state_nxt = LOAD;		// start outside IDLE is dropped.
				end
			end
			LOAD: begin
				state_nxt = OP;
			end
			OP: begin
				state_nxt = SHIFT;
			end
			SHIFT: begin
				if (iter_cnt == LAST_ITER) begin
					state_nxt = DONE;
				end else begin
					state_nxt = OP;
				end
			end
			DONE: begin
				state_nxt = IDLE;
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	// ==============================
	// iteration counter
	// ==============================

	always_ff @(posedge CLOCK or negedge RESET) begin
		if (!RESET) begin
			iter_cnt <= '0;
		end else if (state == LOAD) begin
			iter_cnt <= '0;
		end else if (state == SHIFT) begin
			iter_cnt <= iter_cnt + 1'b1;	// counts finished shifts.
		end
	end

	// ==============================
	// control outputs
	// ==============================

	always_comb begin
		ctl.load	= 1'b0;
		ctl.op_en	= 1'b0;
		ctl.op		= OP_NONE;
		ctl.shift	= 1'b0;
		done		= 1'b0;
		case (state)
			IDLE: begin
				ctl.load = start;		// operands taken at the accepting edge.
			end
			OP: begin
				ctl.op		= win_op;
				ctl.op_en	= (win_op != OP_NONE);
			end
			SHIFT: begin
				ctl.shift = 1'b1;
			end
			DONE: begin
				done = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

//--- src/booth_ctrl_if.sv
`timescale 1ns/1ps

interface booth_ctrl_if
	import booth_pkg::*;
();

	// ==============================
	// sequencer to datapath
	// ==============================

	logic		load;		// capture operands, clear accumulator.
	logic		op_en;		// accumulator takes the add result.
	booth_op_e	op;			// selected booth operation.
	logic		shift;		// arithmetic shift right by two.

	// ==============================
	// datapath to sequencer
	// ==============================

	logic [2:0]	recode;		// {q1, q0, appended bit}.

	modport ctrl (
		output	load,
		output	op_en,
		output	op,
		output	shift,
		input	recode
	);

	modport dp (
		input	load,
		input	op_en,
		input	op,
		input	shift,
		output	recode
	);

endinterface

//--- src/booth_pkg.sv
`include "booth_defines.svh"

package booth_pkg;

	// ==============================
	// data types
	// ==============================

	typedef logic signed [`BOOTH_WIDTH-1:0]		operand_t;
	typedef logic signed [2*`BOOTH_WIDTH-1:0]	product_t;

	// ==============================
	// sequencer states
	// ==============================

	typedef enum logic [2:0] {
		IDLE	= 3'd0,		// waiting for start.
		LOAD	= 3'd1,		// counter cleared.
		OP		= 3'd2,		// add/subtract step.
		SHIFT	= 3'd3,		// pair moves right by two.
		DONE	= 3'd4		// product valid.
	} booth_state_e;

	// ==============================
	// booth operations
	// ==============================

	typedef enum logic [2:0] {
		OP_NONE		= 3'd0,		// 0.
		OP_ADD_M	= 3'd1,		// +M.
		OP_ADD_2M	= 3'd2,		// +2M.
		OP_SUB_M	= 3'd3,		// -M.
		OP_SUB_2M	= 3'd4		// -2M.
	} booth_op_e;

endpackage

//--- src/booth_defines.svh
`ifndef BOOTH_DEFINES_SVH
`define BOOTH_DEFINES_SVH

// ==============================
// operand sizing
// ==============================

`define BOOTH_WIDTH		8						// bits per operand, even, 4 or more.

// ==============================
// derived timing
// ==============================

`define BOOTH_ITER		(`BOOTH_WIDTH / 2)		// two multiplier bits per step.
`define BOOTH_LATENCY	(`BOOTH_WIDTH + 2)		// accepted start to done.

`endif
